/* sources.f */
verilog/dcache_pkg.sv
verilog/dcache_req_buf.sv
verilog/dcache_lru.sv
verilog/dcache_way_store.sv
verilog/dcache_datapath.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/dcache_chk.sv
verification/dcache_tb.sv

/* Makefile */
TOP := dcache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

obj_dir/V$(TOP): sources.f verilog/*.sv verification/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

# pass only if the testbench printed its pass line
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

/* verification/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int          max_mem_delay = 3;
    localparam int          rand_ops      = 60;
    localparam int          directed_ops  = 20;
    localparam int          watchdog_ns   = (rand_ops + directed_ops) *
                                            (2 * max_mem_delay + 10) * 10 + 200;
    localparam logic [31:0] seed          = 32'hc653_4e69;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        req_valid;
    logic        req_ready;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        req_write;
    logic [3:0]  req_wstrb;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        mem_req;
    logic        mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [1:0]  mem_size;
    logic [3:0]  mem_wstrb;
    logic        mem_addr_ok;
    logic        mem_data_ok;
    line_t       mem_rdata;

    // expected contents and the memory model's own contents
    logic [31:0] model_mem [logic [31:0]];
    logic [31:0] store_mem [logic [31:0]];

    int          mem_reads;
    int          mem_writes;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;
    logic [31:0] last_wr_data;
    logic [3:0]  last_wr_strb;
    logic [1:0]  last_size;
    logic        hit_expected;
    string       cur_name;
    int          cur_checks;
    int          cur_errs;
    int          prop_start;
    int          prop_errs = 0;
    int          total_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #5 clk = ~clk;

    dcache_top i_dut (.*);

    assert property (@(posedge clk) disable iff (!arst_n) hit_expected |-> !mem_req)
        else begin
            $display("memory request issued during a read that should hit (%s)", cur_name);
            prop_errs++;
        end

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fill_word(logic [31:0] a);
        return (a ^ 32'h1234_5678) * 32'h9e37_79b1;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] d, logic [3:0] s);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = d[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] model_word(logic [31:0] a);
        return model_mem.exists(a) ? model_mem[a] : fill_word(a);
    endfunction

    function automatic logic [31:0] store_word(logic [31:0] a);
        return store_mem.exists(a) ? store_mem[a] : fill_word(a);
    endfunction

    function automatic logic [31:0] mk_addr(int tag, int idx, int off);
        return (32'(tag) << (index_width + offset_width + 2)) |
               (32'(idx) << (offset_width + 2)) | (32'(off) << 2);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////
    initial begin : mem_model
        logic [31:0] st;
        logic [31:0] a;
        int          d;
        st = seed;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata = '0;
        mem_reads = 0;
        mem_writes = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        last_wr_data = '0;
        last_wr_strb = '0;
        last_size = '0;
        forever begin
            @(posedge clk);
            if (mem_req) begin
                st = lcg_step(st);
                d = int'(st[17:16]) % (max_mem_delay + 1);
                repeat (d) @(posedge clk);
                #1;
                mem_addr_ok = 1'b1;
                a = mem_addr;
                last_size = mem_size;
                if (mem_wr) begin
                    store_mem[a] = merge_bytes(store_word(a), mem_wdata, mem_wstrb);
                    last_wr_addr = a;
                    last_wr_data = mem_wdata;
                    last_wr_strb = mem_wstrb;
                    mem_writes++;
                end else begin
                    for (int w = 0; w < words_per_line; w++) begin
                        mem_rdata[w] = store_word((a & 32'hffff_fff0) | 32'(w << 2));
                    end
                    last_rd_addr = a;
                    mem_reads++;
                end
                // sometimes complete in the address cycle
                st = lcg_step(st);
                mem_data_ok = st[8];
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                if (mem_data_ok) begin
                    mem_data_ok = 1'b0;
                end else begin
                    d = int'(st[21:20]) % (max_mem_delay + 1);
                    repeat (d) @(posedge clk);
                    #1;
                    mem_data_ok = 1'b1;
                    @(posedge clk);
                    #1;
                    mem_data_ok = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and reports
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        cur_checks++;
        assert (act === exp)
            else begin
                $display("mismatch in %s, %s: expected %h, actual %h", cur_name, what, exp, act);
                cur_errs++;
            end
    endtask

    task automatic start_test(input string name);
        cur_name = name;
        cur_checks = 0;
        cur_errs = 0;
        prop_start = prop_errs;
    endtask

    task automatic finish_test();
        int errs;
        errs = cur_errs + prop_errs - prop_start;
        $display("test %s: %0d checks, %0d errors", cur_name, cur_checks, errs);
        tests_run++;
        total_errs += errs;
        if (errs != 0) begin
            tests_failed++;
        end
    endtask

    // one request and the edges from acceptance to response
    task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, output logic [31:0] rdata, output int lat);
        int n;
        n = 0;
        req_valid = 1'b1;
        req_write = wr;
        req_addr = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        @(posedge clk);
        while (!req_ready && n < 100) begin
            @(posedge clk);
            n++;
        end
        #1;
        req_valid = 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!resp_valid && lat < 100);
        rdata = resp_rdata;
        if (!resp_valid) begin
            $display("no response to request at %h in %s", addr, cur_name);
            cur_errs++;
        end
        #1;
    endtask

    task automatic do_read(input logic [31:0] addr, input logic want_hit, input logic want_miss);
        logic [31:0] rdata;
        int          lat;
        int          reads_before;
        reads_before = mem_reads;
        hit_expected = want_hit;
        access(1'b0, addr, '0, 4'h0, rdata, lat);
        hit_expected = 1'b0;
        check_eq("read data", model_word(addr), rdata);
        if (want_hit) begin
            check_eq("hit latency", 32'd1, 32'(lat));
            check_eq("memory reads on hit", 32'(reads_before), 32'(mem_reads));
        end
        if (want_miss) begin
            check_eq("memory reads on miss", 32'(reads_before + 1), 32'(mem_reads));
            check_eq("refill address", addr & 32'hffff_fff0, last_rd_addr);
            // size code 2 is a four-byte access
            check_eq("refill size", 32'd2, 32'(last_size));
        end
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        logic [31:0] rdata;
        int          lat;
        int          writes_before;
        writes_before = mem_writes;
        model_mem[addr] = merge_bytes(model_word(addr), data, strb);
        access(1'b1, addr, data, strb, rdata, lat);
        check_eq("memory writes", 32'(writes_before + 1), 32'(mem_writes));
        check_eq("write address", addr, last_wr_addr);
        check_eq("write data", data, last_wr_data);
        check_eq("write strobe", 32'(strb), 32'(last_wr_strb));
        check_eq("write size", 32'd2, 32'(last_size));
    endtask

    // two hits accepted on consecutive edges
    task automatic read_pair(input logic [31:0] a, input logic [31:0] b);
        int n;
        n = 0;
        hit_expected = 1'b1;
        req_valid = 1'b1;
        req_write = 1'b0;
        req_addr = a;
        @(posedge clk);
        while (!req_ready && n < 100) begin
            @(posedge clk);
            n++;
        end
        #1;
        req_addr = b;
        @(posedge clk);
        check_eq("second accept", 32'd1, 32'(req_ready));
        check_eq("first response", 32'd1, 32'(resp_valid));
        check_eq("first data", model_word(a), resp_rdata);
        #1;
        req_valid = 1'b0;
        @(posedge clk);
        check_eq("second response", 32'd1, 32'(resp_valid));
        check_eq("second data", model_word(b), resp_rdata);
        #1;
        hit_expected = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin : main
        logic [31:0] rnd;
        logic [31:0] a;
        logic [3:0]  strb;
        arst_n = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_write = 1'b0;
        req_wstrb = '0;
        hit_expected = 1'b0;
        rnd = seed;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        start_test("reset");
        repeat (3) begin
            @(posedge clk);
            check_eq("req_ready", 32'd1, 32'(req_ready));
            check_eq("resp_valid", 32'd0, 32'(resp_valid));
            check_eq("mem_req", 32'd0, 32'(mem_req));
        end
        #1;
        finish_test();

        start_test("refill and hits");
        do_read(mk_addr(1, 8, 0), 1'b0, 1'b1);
        do_read(mk_addr(1, 8, 1), 1'b1, 1'b0);
        read_pair(mk_addr(1, 8, 2), mk_addr(1, 8, 3));
        finish_test();

        // absent line stays absent, then a write hit merges bytes
        start_test("write through");
        do_write(mk_addr(2, 9, 1), 32'hdead_beef, 4'hf);
        do_read(mk_addr(2, 9, 1), 1'b0, 1'b1);
        do_write(mk_addr(2, 9, 1), 32'h0bad_f00d, 4'b0101);
        do_read(mk_addr(2, 9, 1), 1'b1, 1'b0);
        do_write(mk_addr(2, 9, 3), 32'h1357_9bdf, 4'b1000);
        do_read(mk_addr(2, 9, 3), 1'b1, 1'b0);
        finish_test();

        start_test("lru");
        do_read(mk_addr(3, 5, 0), 1'b0, 1'b1);
        do_read(mk_addr(4, 5, 0), 1'b0, 1'b1);
        do_read(mk_addr(3, 5, 1), 1'b1, 1'b0);
        do_read(mk_addr(5, 5, 0), 1'b0, 1'b1);
        do_read(mk_addr(3, 5, 2), 1'b1, 1'b0);
        do_read(mk_addr(4, 5, 0), 1'b0, 1'b1);
        finish_test();

        // four tags over two ways keeps misses coming
        start_test("random mix");
        for (int i = 0; i < rand_ops; i++) begin
            rnd = lcg_step(rnd);
            a = mk_addr(6 + int'(rnd[9:8]), int'(rnd[13:12]), int'(rnd[17:16]));
            if (rnd[22:20] < 3'd3) begin
                strb = rnd[27:24];
                if (strb == 4'h0) begin
                    strb = 4'hf;
                end
                rnd = lcg_step(rnd);
                do_write(a, rnd, strb);
            end else begin
                do_read(a, 1'b0, 1'b0);
            end
        end
        finish_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/dcache_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_chk (
    input logic        clk,
    input logic        arst_n,
    input logic        req_valid,
    input logic        req_ready,
    input logic        resp_valid,
    input logic        mem_req,
    input logic        mem_wr,
    input logic [31:0] mem_addr,
    input logic [31:0] mem_wdata,
    input logic [1:0]  mem_size,
    input logic [3:0]  mem_wstrb,
    input logic        mem_addr_ok,
    input logic        mem_data_ok
);

    // request and its fields hold until addr_ok
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_wr) && $stable(mem_addr) &&
            $stable(mem_wdata) && $stable(mem_size) && $stable(mem_wstrb))
        else $error("memory request dropped or changed before addr_ok");

    // a response comes from a lookup or from memory completion
    assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> $past(req_valid && req_ready) || mem_data_ok)
        else $error("response without a lookup or a memory completion");

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |-> !req_ready)
        else $error("cache ready while a memory request is pending");

endmodule

bind dcache_top dcache_chk i_chk (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .mem_req     (mem_req),
    .mem_wr      (mem_wr),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_size    (mem_size),
    .mem_wstrb   (mem_wstrb),
    .mem_addr_ok (mem_addr_ok),
    .mem_data_ok (mem_data_ok)
);

`default_nettype wire

/* verilog/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                clk,
    input  logic                arst_n,
    // pipeline
    input  logic                req_valid,
    output logic                req_ready,
    input  logic [31:0]         req_addr,
    input  logic [31:0]         req_wdata,
    input  logic                req_write,
    input  logic [3:0]          req_wstrb,
    output logic                resp_valid,
    output logic [31:0]         resp_rdata,
    // memory
    output logic                mem_req,
    output logic                mem_wr,
    output logic [31:0]         mem_addr,
    output logic [31:0]         mem_wdata,
    output logic [1:0]          mem_size,
    output logic [3:0]          mem_wstrb,
    input  logic                mem_addr_ok,
    input  logic                mem_data_ok,
    input  dcache_pkg::line_t   mem_rdata
);
    import dcache_pkg::*;

    logic                    buf_load;
    logic [index_width-1:0]  req_index;
    logic [tag_width-1:0]    buf_tag;
    logic [index_width-1:0]  buf_index;
    logic [offset_width-1:0] buf_offset;
    logic [31:0]             buf_addr;
    logic [31:0]             buf_wdata;
    logic                    buf_write;
    logic [3:0]              buf_wstrb;
    logic [index_width-1:0]  rd_index;
    tag_entry_t              tag0;
    tag_entry_t              tag1;
    line_t                   line0;
    line_t                   line1;
    line_t                   merged_line;
    logic [1:0]              tag_we;
    logic [1:0]              data_we;
    logic                    data_sel_refill;
    logic                    lru_victim;
    logic                    lru_use;
    logic                    lru_way;
    logic                    sel_way;

    dcache_req_buf i_req_buf (
        .clk        (clk),
        .arst_n     (arst_n),
        .load       (buf_load),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_write  (req_write),
        .req_wstrb  (req_wstrb),
        .req_index  (req_index),
        .buf_tag    (buf_tag),
        .buf_index  (buf_index),
        .buf_offset (buf_offset),
        .buf_addr   (buf_addr),
        .buf_wdata  (buf_wdata),
        .buf_write  (buf_write),
        .buf_wstrb  (buf_wstrb)
    );

    dcache_lru i_lru (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_index  (buf_index),
        .use_valid (lru_use),
        .use_index (buf_index),
        .use_way   (lru_way),
        .victim    (lru_victim)
    );

    // a refill always installs a valid entry with the buffered tag
    dcache_way_store #(.entry_t(tag_entry_t)) i_tag_store (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_index  (rd_index),
        .rd_entry0 (tag0),
        .rd_entry1 (tag1),
        .wr_index  (buf_index),
        .wr_en     (tag_we),
        .wr_entry  ({1'b1, buf_tag})
    );

    dcache_way_store #(.entry_t(line_t)) i_data_store (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_index  (rd_index),
        .rd_entry0 (line0),
        .rd_entry1 (line1),
        .wr_index  (buf_index),
        .wr_en     (data_we),
        .wr_entry  (merged_line)
    );

    dcache_datapath i_datapath (
        .way0_line   (line0),
        .way1_line   (line1),
        .refill_line (mem_rdata),
        .sel_refill  (data_sel_refill),
        .sel_way     (sel_way),
        .offset      (buf_offset),
        .wdata       (buf_wdata),
        .wstrb       (buf_wstrb),
        .rdata       (resp_rdata),
        .merged_line (merged_line)
    );

    dcache_ctrl i_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .resp_valid      (resp_valid),
        .buf_load        (buf_load),
        .req_index       (req_index),
        .buf_tag         (buf_tag),
        .buf_index       (buf_index),
        .buf_write       (buf_write),
        .buf_wstrb       (buf_wstrb),
        .buf_addr        (buf_addr),
        .buf_wdata       (buf_wdata),
        .rd_index        (rd_index),
        .tag0            (tag0),
        .tag1            (tag1),
        .tag_we          (tag_we),
        .data_we         (data_we),
        .data_sel_refill (data_sel_refill),
        .lru_victim      (lru_victim),
        .lru_use         (lru_use),
        .lru_way         (lru_way),
        .sel_way         (sel_way),
        .mem_req         (mem_req),
        .mem_wr          (mem_wr),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_size        (mem_size),
        .mem_wstrb       (mem_wstrb),
        .mem_addr_ok     (mem_addr_ok),
        .mem_data_ok     (mem_data_ok)
    );

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    // pipeline
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               req_valid,
    output logic                               req_ready,
    output logic                               resp_valid,
    // request buffer
    output logic                               buf_load,
    input  logic [dcache_pkg::index_width-1:0] req_index,
    input  logic [dcache_pkg::tag_width-1:0]   buf_tag,
    input  logic [dcache_pkg::index_width-1:0] buf_index,
    input  logic                               buf_write,
    input  logic [3:0]                         buf_wstrb,
    input  logic [31:0]                        buf_addr,
    input  logic [31:0]                        buf_wdata,
    // arrays
    output logic [dcache_pkg::index_width-1:0] rd_index,
    input  dcache_pkg::tag_entry_t             tag0,
    input  dcache_pkg::tag_entry_t             tag1,
    output logic [1:0]                         tag_we,
    output logic [1:0]                         data_we,
    output logic                               data_sel_refill,
    // lru
    input  logic                               lru_victim,
    output logic                               lru_use,
    output logic                               lru_way,
    // datapath
    output logic                               sel_way,
    // memory
    output logic                               mem_req,
    output logic                               mem_wr,
    output logic [31:0]                        mem_addr,
    output logic [31:0]                        mem_wdata,
    output logic [1:0]                         mem_size,
    output logic [3:0]                         mem_wstrb,
    input  logic                               mem_addr_ok,
    input  logic                               mem_data_ok
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_req,
        st_miss_wait,
        st_wr_req,
        st_wr_wait
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic       hit0;
    logic       hit1;
    logic       hit;
    logic       in_lookup;
    logic       in_refill;
    logic       in_write;
    logic       mem_done;
    logic       refill_done;
    logic [1:0] victim_oh;

    ////////////////////////////////////////////////////////////////////////////
    // hit compare
    ////////////////////////////////////////////////////////////////////////////
    assign hit0 = tag0.valid && (tag0.tag == buf_tag);
    assign hit1 = tag1.valid && (tag1.tag == buf_tag);
    assign hit  = hit0 || hit1;

    assign in_lookup = (state == st_lookup);
    assign in_refill = (state == st_miss_req) || (state == st_miss_wait);
    assign in_write  = (state == st_wr_req) || (state == st_wr_wait);

    // data_ok in a request state only counts together with addr_ok
    assign mem_done = ((state == st_miss_req || state == st_wr_req) && mem_addr_ok &&
                       mem_data_ok) ||
                      ((state == st_miss_wait || state == st_wr_wait) && mem_data_ok);

    assign refill_done = in_refill && mem_done;

    // victim stays valid through the miss, nothing uses the lru meanwhile
    assign victim_oh = lru_victim ? 2'b10 : 2'b01;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline handshake
    ////////////////////////////////////////////////////////////////////////////

    // a read hit frees the cache in the lookup cycle
    assign req_ready  = (state == st_idle) || (in_lookup && !buf_write && hit);
    assign buf_load   = req_valid && req_ready;
    assign rd_index   = buf_load ? req_index : buf_index;
    assign resp_valid = (in_lookup && !buf_write && hit) || mem_done;

    // array and lru updates
    assign tag_we          = refill_done ? victim_oh : 2'b00;
    assign data_we         = refill_done ? victim_oh :
                             (in_lookup && buf_write) ? {hit1, hit0} : 2'b00;
    assign data_sel_refill = in_refill;
    assign sel_way         = hit1;
    assign lru_use         = (in_lookup && hit) || refill_done;
    assign lru_way         = in_lookup ? hit1 : lru_victim;

    ////////////////////////////////////////////////////////////////////////////
    // memory request
    ////////////////////////////////////////////////////////////////////////////

    // fields come from registers only, so they hold until addr_ok
    assign mem_req   = (state == st_miss_req) || (state == st_wr_req);
    assign mem_wr    = in_write;
    assign mem_addr  = in_write ? buf_addr : {buf_tag, buf_index, {(offset_width + 2){1'b0}}};
    assign mem_wdata = buf_wdata;
    assign mem_size  = mem_size_word;
    assign mem_wstrb = in_write ? buf_wstrb : 4'b0000;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (buf_load) begin
                    state_nxt = st_lookup;
                end
            end
            st_lookup: begin
                if (buf_write) begin
                    state_nxt = st_wr_req;
                end else if (!hit) begin
                    state_nxt = st_miss_req;
                end else if (!buf_load) begin
                    state_nxt = st_idle;
                end
            end
            st_miss_req: begin
                if (mem_addr_ok) begin
                    state_nxt = mem_data_ok ? st_idle : st_miss_wait;
                end
            end
            st_wr_req: begin
                if (mem_addr_ok) begin
                    state_nxt = mem_data_ok ? st_idle : st_wr_wait;
                end
            end
            st_miss_wait, st_wr_wait: begin
                if (mem_data_ok) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_datapath (
    input  dcache_pkg::line_t                   way0_line,
    input  dcache_pkg::line_t                   way1_line,
    input  dcache_pkg::line_t                   refill_line,
    input  logic                                sel_refill,
    input  logic                                sel_way,
    input  logic [dcache_pkg::offset_width-1:0] offset,
    input  logic [31:0]                         wdata,
    input  logic [3:0]                          wstrb,
    output logic [31:0]                         rdata,
    output dcache_pkg::line_t                   merged_line
);
    import dcache_pkg::*;

    line_t      way_line;
    line_t      src_line;
    logic [3:0] eff_strb;

    ////////////////////////////////////////////////////////////////////////////
    // line and word select
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        way_line = sel_way ? way1_line : way0_line;
        // refill data goes straight to the pipeline
        src_line = sel_refill ? refill_line : way_line;
        rdata    = src_line[offset];
    end

    ////////////////////////////////////////////////////////////////////////////
    // byte merge
    ////////////////////////////////////////////////////////////////////////////

    // a refill line is stored as it came from memory
    assign eff_strb = sel_refill ? 4'b0000 : wstrb;

    always_comb begin
        merged_line = src_line;
        for (int b = 0; b < 4; b++) begin
            if (eff_strb[b]) begin
                merged_line[offset][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_way_store.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_way_store #(
    parameter type entry_t = dcache_pkg::line_t
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [dcache_pkg::index_width-1:0] rd_index,
    output entry_t                             rd_entry0,
    output entry_t                             rd_entry1,
    input  logic [dcache_pkg::index_width-1:0] wr_index,
    input  logic [1:0]                         wr_en,
    input  entry_t                             wr_entry
);
    import dcache_pkg::*;

    entry_t way0_mem [num_sets];
    entry_t way1_mem [num_sets];

    ////////////////////////////////////////////////////////////////////////////
    // registered read, old contents on a same-edge write
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                way0_mem[s] <= '0;
                way1_mem[s] <= '0;
            end
            rd_entry0 <= '0;
            rd_entry1 <= '0;
        end else begin
            if (wr_en[0]) begin
                way0_mem[wr_index] <= wr_entry;
            end
            if (wr_en[1]) begin
                way1_mem[wr_index] <= wr_entry;
            end
            rd_entry0 <= way0_mem[rd_index];
            rd_entry1 <= way1_mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_lru.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_lru (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [dcache_pkg::index_width-1:0] rd_index,
    input  logic                               use_valid,
    input  logic [dcache_pkg::index_width-1:0] use_index,
    input  logic                               use_way,
    output logic                               victim
);
    import dcache_pkg::*;

    // one bit per set, names the least recently used way
    logic [num_sets-1:0] lru_bits;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_bits <= '0;
        end else if (use_valid) begin
            // the way just used becomes the most recent one
            lru_bits[use_index] <= ~use_way;
        end
    end

    assign victim = lru_bits[rd_index];

endmodule

`default_nettype wire

/* verilog/dcache_req_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_req_buf (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               load,
    input  logic [31:0]                        req_addr,
    input  logic [31:0]                        req_wdata,
    input  logic                               req_write,
    input  logic [3:0]                         req_wstrb,
    output logic [dcache_pkg::index_width-1:0] req_index,
    output logic [dcache_pkg::tag_width-1:0]   buf_tag,
    output logic [dcache_pkg::index_width-1:0] buf_index,
    output logic [dcache_pkg::offset_width-1:0] buf_offset,
    output logic [31:0]                        buf_addr,
    output logic [31:0]                        buf_wdata,
    output logic                               buf_write,
    output logic [3:0]                         buf_wstrb
);
    import dcache_pkg::*;

    // address and access type
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_addr  <= '0;
            buf_write <= 1'b0;
        end else if (load) begin
            buf_addr  <= req_addr;
            buf_write <= req_write;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    // index of the offered request for the read on acceptance
    assign req_index = req_addr[offset_width+2 +: index_width];

    // tag | index | word offset | byte
    assign buf_offset = buf_addr[2 +: offset_width];
    assign buf_index  = buf_addr[offset_width+2 +: index_width];
    assign buf_tag    = buf_addr[31 -: tag_width];

endmodule

`default_nettype wire

/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int index_width    = 4;
    localparam int offset_width   = 2;
    localparam int words_per_line = 1 << offset_width;
    localparam int num_sets       = 1 << index_width;

    // byte offset inside a word takes the last two bits
    localparam int tag_width = 32 - index_width - offset_width - 2;

    // memory size code for a full word access
    localparam logic [1:0] mem_size_word = 2'd2;

    // one line, word 0 in the low bits
    typedef logic [words_per_line-1:0][31:0] line_t;

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
    } tag_entry_t;

endpackage

`default_nettype wire
